// File: Bender.yml
package:
  name: timer_unit

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/timer_unit_pkg.sv
      - src/timer_prescaler.sv
      - src/timer_counter.sv
      - src/timer_regs.sv
      - src/timer_unit.sv

  - target: test
    include_dirs:
      - src
    files:
      - dv/timer_unit_tb.sv

// File: dv/timer_unit_tb.sv
//////////////////////////////////////////////////////////////////////
// table-driven testbench with inputs changing on falling edges only
// irq bounds assume one channel runs with its irq enabled at a time
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "timer_unit_macros.svh"

module timer_unit_tb
   import timer_unit_pkg::*;
();

   localparam int CLK_PERIOD = 40;
   localparam apb_data_t CFG_MASK = (32'h1 << `TIMER_CFG_EN) | (32'h1 << `TIMER_CFG_IRQ_EN)
      | (32'h1 << `TIMER_CFG_CLR_MATCH) | (32'h1 << `TIMER_CFG_PRESC_EN)
      | (32'hFF << `TIMER_CFG_PRESC_LSB);

   typedef enum logic [3:0] {
      OP_WR, OP_RD, OP_RD_MAX, OP_SNAP, OP_SAME, OP_WAIT_LO, OP_WAIT_HI, OP_QUIET, OP_STOP
   } op_e;

   typedef struct packed {
      op_e       op;
      apb_addr_t addr;
      apb_data_t data;
      apb_data_t exp_val;  // read value, read limit or earliest irq cycle
      logic      err;
      int        bound;    // cycles the entry may take
   } entry_t;

   logic      clk_i, reset_i, stoptimer_i;
   logic      psel_i, penable_i, pwrite_i;
   apb_addr_t paddr_i;
   apb_data_t pwdata_i, prdata_o;
   logic      pready_o, pslverr_o, irq_lo_o, irq_hi_o;

   entry_t      tbl[$];
   logic [31:0] lfsr;
   int          total_cycles = 0;
   logic        table_ready = 1'b0;
   apb_data_t   snap_val;

   timer_unit uut (.*);

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD/2) clk_i = ~clk_i;
   end

   // taps x^32 + x^22 + x^2 + x + 1 stepped once per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      int          i;
      v = '0;
      for (i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic void add_entry(input op_e op, input apb_addr_t addr, input apb_data_t data,
                                     input apb_data_t exp_val, input logic err, input int bound);
      entry_t e;
      e.op      = op;
      e.addr    = addr;
      e.data    = data;
      e.exp_val = exp_val;
      e.err     = err;
      e.bound   = bound;
      tbl.push_back(e);
      total_cycles += bound;
   endfunction

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("error: %s got 0x%08h expected 0x%08h", name, actual, expected);
         $display("Test FAILED");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Test FAILED");
      $fatal(1, "stopped on failure");
   endtask

   task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
      @(negedge clk_i);
      psel_i    = 1'b1;
      penable_i = 1'b0;
      pwrite_i  = 1'b1;
      paddr_i   = addr;
      pwdata_i  = data;
      @(negedge clk_i);
      penable_i = 1'b1;
      #(CLK_PERIOD/4);  // mid access cycle
      err = pslverr_o;
      check_value("pready_o", pready_o, 1'b1);
      @(negedge clk_i);  // write landed on the edge before
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
   endtask

   task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
      @(negedge clk_i);
      psel_i    = 1'b1;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
      paddr_i   = addr;
      @(negedge clk_i);
      penable_i = 1'b1;
      #(CLK_PERIOD/4);
      data = prdata_o;
      err  = pslverr_o;
      check_value("pready_o", pready_o, 1'b1);
      @(negedge clk_i);
      psel_i    = 1'b0;
      penable_i = 1'b0;
   endtask

   // counts falling edges while the other irq stays low
   task automatic wait_irq(input logic use_hi, input int min_cyc, input int max_cyc);
      int   n;
      logic seen;
      n    = 0;
      seen = 1'b0;
      while (!seen && n < max_cyc) begin
         @(negedge clk_i);
         n++;
         seen = use_hi ? irq_hi_o : irq_lo_o;
         check_value(use_hi ? "irq_lo_o" : "irq_hi_o", use_hi ? irq_lo_o : irq_hi_o, 1'b0);
      end
      if (!seen) begin
         report_failure($sformatf("%s never pulsed within %0d cycles",
                                  use_hi ? "irq_hi_o" : "irq_lo_o", max_cyc));
      end else if (n < min_cyc) begin
         report_failure($sformatf("%s pulsed after %0d cycles, earlier than %0d",
                                  use_hi ? "irq_hi_o" : "irq_lo_o", n, min_cyc));
      end
   endtask

   task automatic quiet_window(input int cycles);
      int n;
      for (n = 0; n < cycles; n++) begin
         @(negedge clk_i);
         check_value("irq_lo_o", irq_lo_o, 1'b0);
         check_value("irq_hi_o", irq_hi_o, 1'b0);
      end
   endtask

   task automatic run_entry(input entry_t e);
      apb_data_t rd;
      logic      err;
      case (e.op)
         OP_WR: begin
            apb_write(e.addr, e.data, err);
            check_value($sformatf("pslverr_o[%03h]", e.addr), err, e.err);
         end
         OP_RD, OP_RD_MAX, OP_SNAP, OP_SAME: begin
            apb_read(e.addr, rd, err);
            check_value($sformatf("pslverr_o[%03h]", e.addr), err, e.err);
            if (e.op == OP_RD) begin
               check_value($sformatf("prdata_o[%03h]", e.addr), rd, e.exp_val);
            end else if (e.op == OP_RD_MAX && rd > e.exp_val) begin
               check_value($sformatf("prdata_o[%03h] limit", e.addr), rd, e.exp_val);
            end else if (e.op == OP_SNAP) begin
               snap_val = rd;
            end else if (e.op == OP_SAME) begin
               check_value($sformatf("prdata_o[%03h] held", e.addr), rd, snap_val);
            end
         end
         OP_WAIT_LO: wait_irq(1'b0, e.exp_val, e.bound);
         OP_WAIT_HI: wait_irq(1'b1, e.exp_val, e.bound);
         OP_QUIET:   quiet_window(e.bound);
         OP_STOP: begin
            @(negedge clk_i);
            stoptimer_i = e.data[0];
         end
         default: report_failure("unknown table operation");
      endcase
   endtask

   function automatic void build_table();
      apb_data_t c_lo, c_hi, p_hi, d;
      apb_data_t cfg_lo_v, cfg_hi_v, cmp_lo_v, cmp_hi_v;
      int        b_lo, b_hi, k;
      add_entry(OP_QUIET, 0, 0, 0, 0, 4);
      for (k = 0; k < 8; k++) begin
         add_entry(OP_RD, k * 4, 0, 0, 0, 3);  // reset values
      end
      cmp_lo_v = rand_bits(32);
      add_entry(OP_WR, `TIMER_CMP_LO, cmp_lo_v, 0, 0, 3);
      add_entry(OP_RD, `TIMER_CMP_LO, 0, cmp_lo_v, 0, 3);
      cmp_hi_v = rand_bits(32);
      add_entry(OP_WR, `TIMER_CMP_HI, cmp_hi_v, 0, 0, 3);
      add_entry(OP_RD, `TIMER_CMP_HI, 0, cmp_hi_v, 0, 3);
      d = rand_bits(32) & ~32'h1;  // channel stays disabled
      add_entry(OP_WR, `TIMER_CFG_LO, d, 0, 0, 3);
      add_entry(OP_RD, `TIMER_CFG_LO, 0, d & CFG_MASK, 0, 3);
      d = rand_bits(32) & ~32'h1;
      add_entry(OP_WR, `TIMER_CFG_HI, d, 0, 0, 3);
      add_entry(OP_RD, `TIMER_CFG_HI, 0, d & CFG_MASK, 0, 3);
      d = rand_bits(32);
      add_entry(OP_WR, `TIMER_CNT_LO, d, 0, 0, 3);
      add_entry(OP_RD, `TIMER_CNT_LO, 0, d, 0, 3);
      d = rand_bits(32);
      add_entry(OP_WR, `TIMER_CNT_HI, d, 0, 0, 3);
      add_entry(OP_RD, `TIMER_CNT_HI, 0, d, 0, 3);

      // low channel without prescaler in clear-on-match mode
      c_lo     = rand_bits(4);
      b_lo     = c_lo + 1 + 3;
      cmp_lo_v = c_lo;
      cfg_lo_v = (32'h1 << `TIMER_CFG_EN) | (32'h1 << `TIMER_CFG_IRQ_EN)
                 | (32'h1 << `TIMER_CFG_CLR_MATCH);
      add_entry(OP_WR, `TIMER_RST_LO, 0, 0, 0, 3);
      add_entry(OP_WR, `TIMER_CMP_LO, c_lo, 0, 0, 3);
      add_entry(OP_WR, `TIMER_CFG_LO, cfg_lo_v, 0, 0, 3);
      add_entry(OP_WAIT_LO, 0, 0, c_lo, 0, b_lo);
      add_entry(OP_WAIT_LO, 0, 0, c_lo, 0, b_lo);
      add_entry(OP_WR, `TIMER_CFG_LO, 0, 0, 0, 3);

      // high channel free running with prescaler
      c_hi     = rand_bits(4);
      p_hi     = rand_bits(2) + 1;
      b_hi     = (c_hi + 1) * (p_hi + 1) + 3;
      cmp_hi_v = c_hi;
      cfg_hi_v = (32'h1 << `TIMER_CFG_EN) | (32'h1 << `TIMER_CFG_IRQ_EN)
                 | (32'h1 << `TIMER_CFG_PRESC_EN) | (p_hi << `TIMER_CFG_PRESC_LSB);
      add_entry(OP_WR, `TIMER_RST_HI, 0, 0, 0, 3);
      add_entry(OP_WR, `TIMER_CMP_HI, c_hi, 0, 0, 3);
      add_entry(OP_WR, `TIMER_CFG_HI, cfg_hi_v, 0, 0, 3);
      add_entry(OP_WAIT_HI, 0, 0, (c_hi + 1) * (p_hi + 1) - 1, 0, b_hi);
      add_entry(OP_WR, `TIMER_RST_HI, 0, 0, 0, 3);
      add_entry(OP_RD_MAX, `TIMER_CNT_HI, 0, 2, 0, 3);

      // irq enable off and then debug stop
      cfg_hi_v = cfg_hi_v & ~(32'h1 << `TIMER_CFG_IRQ_EN);
      add_entry(OP_WR, `TIMER_CFG_HI, cfg_hi_v, 0, 0, 3);
      add_entry(OP_WR, `TIMER_RST_HI, 0, 0, 0, 3);  // next match lands inside the window
      add_entry(OP_QUIET, 0, 0, 0, 0, 2 * b_hi);
      add_entry(OP_STOP, 0, 1, 0, 0, 1);
      add_entry(OP_WR, `TIMER_RST_LO, 0, 0, 0, 3);
      add_entry(OP_WR, `TIMER_CFG_LO, cfg_lo_v, 0, 0, 3);
      add_entry(OP_RD, `TIMER_CNT_LO, 0, 0, 0, 3);
      add_entry(OP_SNAP, `TIMER_CNT_HI, 0, 0, 0, 3);
      add_entry(OP_QUIET, 0, 0, 0, 0, 2 * b_lo);
      add_entry(OP_RD, `TIMER_CNT_LO, 0, 0, 0, 3);
      add_entry(OP_SAME, `TIMER_CNT_HI, 0, 0, 0, 3);
      add_entry(OP_STOP, 0, 0, 0, 0, 1);
      add_entry(OP_WAIT_LO, 0, 0, c_lo, 0, b_lo);

      // unmapped and unaligned accesses
      add_entry(OP_RD, 12'h030, 0, 0, 1, 3);
      add_entry(OP_RD, 12'h011, 0, 0, 1, 3);
      add_entry(OP_WR, 12'h030, rand_bits(32), 0, 1, 3);
      add_entry(OP_WR, 12'h012, rand_bits(32), 0, 1, 3);
      add_entry(OP_WR, 12'h005, rand_bits(32), 0, 1, 3);
      add_entry(OP_RD, `TIMER_CFG_LO, 0, cfg_lo_v, 0, 3);
      add_entry(OP_RD, `TIMER_CFG_HI, 0, cfg_hi_v, 0, 3);
      add_entry(OP_RD, `TIMER_CMP_LO, 0, cmp_lo_v, 0, 3);
      add_entry(OP_RD, `TIMER_CMP_HI, 0, cmp_hi_v, 0, 3);
   endfunction

   initial begin
      int idx;
      reset_i     = 1'b1;
      stoptimer_i = 1'b0;
      psel_i      = 1'b0;
      penable_i   = 1'b0;
      pwrite_i    = 1'b0;
      paddr_i     = '0;
      pwdata_i    = '0;
      lfsr        = 32'hc8740ca5;
      build_table();
      table_ready = 1'b1;
      repeat (5) @(negedge clk_i);
      reset_i = 1'b0;
      for (idx = 0; idx < tbl.size(); idx++) begin
         run_entry(tbl[idx]);
      end
      $display("Test OK");
      $finish;
   end

   // watchdog over the sum of table bounds plus margin
   initial begin
      wait (table_ready);
      #((total_cycles + 100) * CLK_PERIOD);
      $display("timeout: the table did not finish within %0d cycles", total_cycles + 100);
      $display("Test FAILED");
      $fatal(1, "watchdog expired");
   end

endmodule : timer_unit_tb

// File: src/timer_counter.sv
//////////////////////////////////////////////////////////////////////
// channel counter, advances on ticks only and wraps at 2^32
// clear beats load, both beat a tick; irq_o is a registered pulse
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module timer_counter
   import timer_unit_pkg::*;
(
   input  logic clk_i,
   input  logic reset_i,
   input  logic tick_i,
   input  logic clear_i,
   input  logic load_i,
   input  logic clear_on_match_i,
   input  logic irq_en_i,
   input  cnt_t load_value_i,
   input  cnt_t cmp_i,
   output cnt_t count_o,
   output logic irq_o
);

   cnt_t count_q;
   logic irq_q;
   logic match;

   assign match = (count_q == cmp_i);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         count_q <= '0;
         irq_q   <= 1'b0;
      end else begin
         irq_q <= 1'b0;  // pulse lasts one cycle
         if (clear_i) begin
            count_q <= '0;
         end else if (load_i) begin
            count_q <= load_value_i;
         end else if (tick_i) begin
            if (match) begin
               irq_q <= irq_en_i;
               // restart period in clear-on-match mode
               if (clear_on_match_i) begin
                  count_q <= '0;
               end else begin
                  count_q <= count_q + 1'b1;
               end
            end else begin
               count_q <= count_q + 1'b1;
            end
         end
      end
   end

   assign count_o = count_q;
   assign irq_o   = irq_q;

endmodule : timer_counter

// File: src/timer_prescaler.sv
//////////////////////////////////////////////////////////////////////
// tick generator, one tick per presc_i+1 running cycles when enabled
// tick_o is combinational from the divide count and the run inputs
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module timer_prescaler
   import timer_unit_pkg::*;
(
   input  logic   clk_i,
   input  logic   reset_i,
   input  logic   enable_i,
   input  logic   stop_i,
   input  logic   presc_en_i,
   input  logic   clear_i,
   input  presc_t presc_i,
   output logic   tick_o
);

   logic   run;
   logic   wrap;
   presc_t div_q;

   assign run  = enable_i & ~stop_i;  // frozen by debug stop
   assign wrap = (div_q >= presc_i);  // >= so a smaller new ratio still wraps

   // bypass ticks on every running cycle
   assign tick_o = run & (~presc_en_i | wrap);

   always_ff @(posedge clk_i) begin
      if (reset_i || clear_i) begin
         div_q <= '0;
      end else if (!presc_en_i) begin
         div_q <= '0;  // restart cleanly when prescaler is turned on
      end else if (run) begin
         if (wrap) begin
            div_q <= '0;
         end else begin
            div_q <= div_q + 1'b1;
         end
      end
   end

endmodule : timer_prescaler

// File: src/timer_regs.sv
//////////////////////////////////////////////////////////////////////
// APB slave, no wait states; writes land on the edge ending access
// unmapped or unaligned offsets flag pslverr_o and read zero
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "timer_unit_macros.svh"

module timer_regs
   import timer_unit_pkg::*;
(
   input  logic      clk_i,
   input  logic      reset_i,
   input  logic      psel_i,
   input  logic      penable_i,
   input  logic      pwrite_i,
   input  apb_addr_t paddr_i,
   input  apb_data_t pwdata_i,
   output apb_data_t prdata_o,
   output logic      pready_o,
   output logic      pslverr_o,
   input  cnt_t      lo_count_i,
   input  cnt_t      hi_count_i,
   output logic      lo_enable_o,
   output logic      lo_presc_en_o,
   output logic      lo_irq_en_o,
   output logic      lo_clear_on_match_o,
   output logic      lo_clear_o,
   output logic      lo_load_o,
   output presc_t    lo_presc_o,
   output cnt_t      lo_cmp_o,
   output cnt_t      lo_load_value_o,
   output logic      hi_enable_o,
   output logic      hi_presc_en_o,
   output logic      hi_irq_en_o,
   output logic      hi_clear_on_match_o,
   output logic      hi_clear_o,
   output logic      hi_load_o,
   output presc_t    hi_presc_o,
   output cnt_t      hi_cmp_o,
   output cnt_t      hi_load_value_o
);

   apb_data_t cfg_lo_q;
   apb_data_t cfg_hi_q;
   cnt_t      cmp_lo_q;
   cnt_t      cmp_hi_q;
   apb_data_t rdata;
   logic      addr_hit;
   logic      wr_en;

   // keep only the defined cfg fields
   function automatic apb_data_t cfg_mask(input apb_data_t d);
      apb_data_t m;
      m = '0;
      m[`TIMER_CFG_EN]        = d[`TIMER_CFG_EN];
      m[`TIMER_CFG_IRQ_EN]    = d[`TIMER_CFG_IRQ_EN];
      m[`TIMER_CFG_CLR_MATCH] = d[`TIMER_CFG_CLR_MATCH];
      m[`TIMER_CFG_PRESC_EN]  = d[`TIMER_CFG_PRESC_EN];
      m[`TIMER_CFG_PRESC_LSB +: `TIMER_PRESC_W] = d[`TIMER_CFG_PRESC_LSB +: `TIMER_PRESC_W];
      return m;
   endfunction

   assign wr_en = psel_i & penable_i & pwrite_i;

   // full-address match, so unaligned addresses fall to default
   always_comb begin
      addr_hit = 1'b1;
      rdata    = '0;
      case (paddr_i)
         `TIMER_CFG_LO: rdata = cfg_lo_q;
         `TIMER_CFG_HI: rdata = cfg_hi_q;
         `TIMER_CNT_LO: rdata = lo_count_i;  // live count
         `TIMER_CNT_HI: rdata = hi_count_i;
         `TIMER_CMP_LO: rdata = cmp_lo_q;
         `TIMER_CMP_HI: rdata = cmp_hi_q;
         `TIMER_RST_LO, `TIMER_RST_HI: rdata = '0;
         default: addr_hit = 1'b0;
      endcase
   end

   assign prdata_o  = rdata;
   assign pready_o  = 1'b1;
   assign pslverr_o = psel_i & penable_i & ~addr_hit;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         cfg_lo_q <= '0;
         cfg_hi_q <= '0;
         cmp_lo_q <= '0;
         cmp_hi_q <= '0;
      end else if (wr_en) begin
         case (paddr_i)
            `TIMER_CFG_LO: cfg_lo_q <= cfg_mask(pwdata_i);
            `TIMER_CFG_HI: cfg_hi_q <= cfg_mask(pwdata_i);
            `TIMER_CMP_LO: cmp_lo_q <= pwdata_i;
            `TIMER_CMP_HI: cmp_hi_q <= pwdata_i;
            default: ;  // cnt and rst handled as pulses below
         endcase
      end
   end

   // load and clear pulses, one access cycle long
   assign lo_load_o       = wr_en & (paddr_i == `TIMER_CNT_LO);
   assign hi_load_o       = wr_en & (paddr_i == `TIMER_CNT_HI);
   assign lo_clear_o      = wr_en & (paddr_i == `TIMER_RST_LO);
   assign hi_clear_o      = wr_en & (paddr_i == `TIMER_RST_HI);
   assign lo_load_value_o = pwdata_i;
   assign hi_load_value_o = pwdata_i;

   assign lo_enable_o         = cfg_lo_q[`TIMER_CFG_EN];
   assign lo_irq_en_o         = cfg_lo_q[`TIMER_CFG_IRQ_EN];
   assign lo_clear_on_match_o = cfg_lo_q[`TIMER_CFG_CLR_MATCH];
   assign lo_presc_en_o       = cfg_lo_q[`TIMER_CFG_PRESC_EN];
   assign lo_presc_o          = cfg_lo_q[`TIMER_CFG_PRESC_LSB +: `TIMER_PRESC_W];
   assign lo_cmp_o            = cmp_lo_q;

   assign hi_enable_o         = cfg_hi_q[`TIMER_CFG_EN];
   assign hi_irq_en_o         = cfg_hi_q[`TIMER_CFG_IRQ_EN];
   assign hi_clear_on_match_o = cfg_hi_q[`TIMER_CFG_CLR_MATCH];
   assign hi_presc_en_o       = cfg_hi_q[`TIMER_CFG_PRESC_EN];
   assign hi_presc_o          = cfg_hi_q[`TIMER_CFG_PRESC_LSB +: `TIMER_PRESC_W];
   assign hi_cmp_o            = cmp_hi_q;

endmodule : timer_regs

// File: src/timer_unit.sv
//////////////////////////////////////////////////////////////////////
// two independent 32-bit timer channels behind one APB slave
// stoptimer_i freezes both prescalers, so both counts hold
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module timer_unit
   import timer_unit_pkg::*;
(
   input  logic      clk_i,
   input  logic      reset_i,
   input  logic      stoptimer_i,
   input  logic      psel_i,
   input  logic      penable_i,
   input  logic      pwrite_i,
   input  apb_addr_t paddr_i,
   input  apb_data_t pwdata_i,
   output apb_data_t prdata_o,
   output logic      pready_o,
   output logic      pslverr_o,
   output logic      irq_lo_o,
   output logic      irq_hi_o
);

   logic   lo_enable, hi_enable;
   logic   lo_presc_en, hi_presc_en;
   logic   lo_irq_en, hi_irq_en;
   logic   lo_clear_on_match, hi_clear_on_match;
   logic   lo_clear, hi_clear;
   logic   lo_load, hi_load;
   logic   lo_tick, hi_tick;
   presc_t lo_presc, hi_presc;
   cnt_t   lo_cmp, hi_cmp;
   cnt_t   lo_load_value, hi_load_value;
   cnt_t   lo_count, hi_count;

   timer_regs u_regs (
      .clk_i               (clk_i),
      .reset_i             (reset_i),
      .psel_i              (psel_i),
      .penable_i           (penable_i),
      .pwrite_i            (pwrite_i),
      .paddr_i             (paddr_i),
      .pwdata_i            (pwdata_i),
      .prdata_o            (prdata_o),
      .pready_o            (pready_o),
      .pslverr_o           (pslverr_o),
      .lo_count_i          (lo_count),
      .hi_count_i          (hi_count),
      .lo_enable_o         (lo_enable),
      .lo_presc_en_o       (lo_presc_en),
      .lo_irq_en_o         (lo_irq_en),
      .lo_clear_on_match_o (lo_clear_on_match),
      .lo_clear_o          (lo_clear),
      .lo_load_o           (lo_load),
      .lo_presc_o          (lo_presc),
      .lo_cmp_o            (lo_cmp),
      .lo_load_value_o     (lo_load_value),
      .hi_enable_o         (hi_enable),
      .hi_presc_en_o       (hi_presc_en),
      .hi_irq_en_o         (hi_irq_en),
      .hi_clear_on_match_o (hi_clear_on_match),
      .hi_clear_o          (hi_clear),
      .hi_load_o           (hi_load),
      .hi_presc_o          (hi_presc),
      .hi_cmp_o            (hi_cmp),
      .hi_load_value_o     (hi_load_value)
   );

   // low channel
   timer_prescaler u_presc_lo (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .enable_i   (lo_enable),
      .stop_i     (stoptimer_i),
      .presc_en_i (lo_presc_en),
      .clear_i    (lo_clear),
      .presc_i    (lo_presc),
      .tick_o     (lo_tick)
   );

   timer_counter u_cnt_lo (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .tick_i           (lo_tick),
      .clear_i          (lo_clear),
      .load_i           (lo_load),
      .clear_on_match_i (lo_clear_on_match),
      .irq_en_i         (lo_irq_en),
      .load_value_i     (lo_load_value),
      .cmp_i            (lo_cmp),
      .count_o          (lo_count),
      .irq_o            (irq_lo_o)
   );

   // high channel
   timer_prescaler u_presc_hi (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .enable_i   (hi_enable),
      .stop_i     (stoptimer_i),
      .presc_en_i (hi_presc_en),
      .clear_i    (hi_clear),
      .presc_i    (hi_presc),
      .tick_o     (hi_tick)
   );

   timer_counter u_cnt_hi (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .tick_i           (hi_tick),
      .clear_i          (hi_clear),
      .load_i           (hi_load),
      .clear_on_match_i (hi_clear_on_match),
      .irq_en_i         (hi_irq_en),
      .load_value_i     (hi_load_value),
      .cmp_i            (hi_cmp),
      .count_o          (hi_count),
      .irq_o            (irq_hi_o)
   );

endmodule : timer_unit

// File: src/timer_unit_macros.svh
//////////////////////////////////////////////////////////////////////
// widths, register offsets and cfg bit positions of the timer unit
// offsets are byte addresses, only word-aligned accesses decode
//////////////////////////////////////////////////////////////////////

`ifndef TIMER_UNIT_MACROS_SVH
`define TIMER_UNIT_MACROS_SVH

`define TIMER_CNT_W   32
`define TIMER_PRESC_W 8
`define TIMER_ADDR_W  12
`define TIMER_DATA_W  32

// register map
`define TIMER_CFG_LO 12'h000
`define TIMER_CFG_HI 12'h004
`define TIMER_CNT_LO 12'h008  // write loads the counter
`define TIMER_CNT_HI 12'h00C
`define TIMER_CMP_LO 12'h010
`define TIMER_CMP_HI 12'h014
`define TIMER_RST_LO 12'h018  // write-only, reads zero
`define TIMER_RST_HI 12'h01C

// cfg fields
`define TIMER_CFG_EN        0
`define TIMER_CFG_IRQ_EN    2
`define TIMER_CFG_CLR_MATCH 4
`define TIMER_CFG_PRESC_EN  6
`define TIMER_CFG_PRESC_LSB 8

`endif

// File: src/timer_unit_pkg.sv
//////////////////////////////////////////////////////////////////////
// vector types shared by the timer RTL and its testbench
//////////////////////////////////////////////////////////////////////

`include "timer_unit_macros.svh"

package timer_unit_pkg;

   // counter and compare value
   typedef logic [`TIMER_CNT_W-1:0] cnt_t;

   // prescaler divide ratio
   typedef logic [`TIMER_PRESC_W-1:0] presc_t;

   // apb bus
   typedef logic [`TIMER_ADDR_W-1:0] apb_addr_t;
   typedef logic [`TIMER_DATA_W-1:0] apb_data_t;

endpackage : timer_unit_pkg

// File: timer_unit.f
+incdir+src
src/timer_unit_pkg.sv
src/timer_prescaler.sv
src/timer_counter.sv
src/timer_regs.sv
src/timer_unit.sv
dv/timer_unit_tb.sv
